// ==== logic/net_config.svh ====
// Build-time constants for the CPU receive port
// The MAC filter packs the destination address from two 32-bit beats,
// so NET_DATA_W must stay at 32 unless that filter changes too
// A bytes value of 0 on a last beat means the whole word is valid
`ifndef NET_CONFIG_SVH
`define NET_CONFIG_SVH

// Stream beat width and its valid-byte count
`define NET_DATA_W 32
`define NET_BYTES_W 2

// Packet FIFO holds 2**NET_FIFO_LG beats
`define NET_FIFO_LG 5

// Station address, byte 0 on the wire is the top byte
`define NET_CPU_MAC 48'h02005e102030

// Register word address width on the Wishbone port
`define CSR_ADDR_W 3

`endif

// ==== logic/net_pkg.sv ====
// Packet stream types shared by the filter, the FIFO and the top level
// Byte 0 on the wire sits in data bits 7:0 of a beat
// The bytes field only means something on a last beat
`include "net_config.svh"

package net_pkg;

	// One station address, most significant byte first on the wire
	typedef logic [47:0] mac_t;

	//////////////////////////////////////////////////
	// Stream beat
	//////////////////////////////////////////////////

	// Valid and abort travel beside the beat, not inside it
	typedef struct packed {
		// Payload, byte 0 in the low bits
		logic [`NET_DATA_W-1:0]  data;
		// Valid bytes on the last beat, 0 means all
		logic [`NET_BYTES_W-1:0] bytes;
		// Final beat of the packet
		logic                    last;
	} rx_beat_t;

endpackage

// ==== logic/csr_pkg.sv ====
// Wishbone classic request/response types and the register map
// No stall signal, one transfer per cyc/stb/ack handshake
// Unlisted register addresses read back as zero
`include "net_config.svh"

package csr_pkg;

	//////////////////////////////////////////////////
	// Wishbone classic
	//////////////////////////////////////////////////

	// Master side, held until ack
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`CSR_ADDR_W-1:0] addr;
		logic [31:0]            data;
		logic [3:0]             sel;
	} wb_req_t;

	// Slave side, data valid with ack
	typedef struct packed {
		logic        ack;
		logic [31:0] data;
	} wb_rsp_t;

	// Control register, enable in bit 1 and promiscuous in bit 0
	typedef struct packed {
		logic enable;
		logic promiscuous;
	} csr_ctrl_t;

	// Register word addresses
	typedef enum logic [`CSR_ADDR_W-1:0] {
		CONTROL  = 3'd0,
		MAC_HI   = 3'd1,
		MAC_LO   = 3'd2,
		RX_DROPS = 3'd3,
		RX_PKTS  = 3'd4
	} csr_addr_e;

endpackage

// ==== logic/rx_mac_filter.sv ====
// Destination MAC filter, one register stage, no back-pressure
// Every input beat shows up one cycle later or is swallowed
// After an abort the sender still closes the packet with a last beat;
// the beats up to and including that last are swallowed
// An o_abort ends the packet as far as the FIFO is concerned
`timescale 1ns/1ns
`include "net_config.svh"

module rx_mac_filter (
	input  logic                i_clk,
	input  logic                i_reset,
	input  csr_pkg::csr_ctrl_t  i_ctrl,
	input  logic                i_valid,
	input  net_pkg::rx_beat_t   i_beat,
	input  logic                i_abort,
	output logic                o_valid,
	output net_pkg::rx_beat_t   o_beat,
	output logic                o_abort
);

	// Packet position and disposition
	logic in_pkt;
	logic second;
	logic skip;
	logic pkt_en;
	// First beat, holds destination bytes 0 to 3
	logic [`NET_DATA_W-1:0] first_word;
	logic live;
	logic mac_ok;
	net_pkg::mac_t dest;

	// Forwarding allowed for this beat
	assign live = in_pkt ? (pkt_en && !skip) : i_ctrl.enable;

	// Bytes 0..5, byte 0 most significant
	assign dest = {first_word[7:0], first_word[15:8], first_word[23:16],
		first_word[31:24], i_beat.data[7:0], i_beat.data[15:8]};

	// Own address, broadcast, or anything when promiscuous
	assign mac_ok = i_ctrl.promiscuous || (dest == `NET_CPU_MAC) || (&dest);

	//////////////////////////////////////////////////
	// Packet tracking
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			in_pkt  <= 1'b0;
			second  <= 1'b0;
			skip    <= 1'b0;
			pkt_en  <= 1'b0;
			o_valid <= 1'b0;
			o_abort <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			o_abort <= 1'b0;
			if (i_abort && (in_pkt || i_valid)) begin
				// Sender abort, flag once then swallow to last
				o_abort <= live;
				in_pkt  <= !(i_valid && i_beat.last);
				pkt_en  <= in_pkt ? pkt_en : i_ctrl.enable;
				second  <= 1'b0;
				skip    <= 1'b1;
			end else if (i_valid) begin
				in_pkt <= !i_beat.last;
				if (!in_pkt) begin
					// First beat latches enable
					pkt_en  <= i_ctrl.enable;
					second  <= !i_beat.last;
					skip    <= 1'b0;
					// One-beat packet is too short
					o_valid <= live && !i_beat.last;
					o_abort <= live && i_beat.last;
				end else if (second) begin
					// MAC decided here
					second  <= 1'b0;
					skip    <= !mac_ok;
					o_valid <= live && mac_ok;
					o_abort <= live && !mac_ok;
				end else begin
					o_valid <= live;
				end
			end
		end
	end

	// Payload capture
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_beat <= i_beat;
		end
		if (i_valid && !in_pkt) begin
			first_word <= i_beat.data;
		end
	end

endmodule

// ==== logic/rx_packet_fifo.sv ====
// Packet FIFO, releases a packet only after its last beat is stored
// The write side is never stalled: a beat that finds the FIFO full
// drops the whole packet, which is then ignored up to its last beat
// An input abort ends the packet at once and drops whatever was stored
// Output holds valid and data steady while ready is low
`timescale 1ns/1ns
`include "net_config.svh"

module rx_packet_fifo (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_valid,
	input  net_pkg::rx_beat_t  i_beat,
	input  logic               i_abort,
	output logic               o_rx_valid,
	output net_pkg::rx_beat_t  o_rx_beat,
	input  logic               i_rx_ready,
	output logic               o_pkt_done,
	output logic               o_pkt_drop
);

	localparam int LG    = `NET_FIFO_LG;
	localparam int DEPTH = 1 << LG;

	net_pkg::rx_beat_t mem [DEPTH];

	// Extra msb tells full from empty
	logic [LG:0] rd_ptr;
	logic [LG:0] wr_cmt;
	logic [LG:0] wr_ptr;
	// Discarding the tail of an overflowed packet
	logic dropping;
	logic full;
	logic wr_beat;
	logic have_pkt;
	logic load;

	assign full = (wr_ptr[LG] != rd_ptr[LG]) && (wr_ptr[LG-1:0] == rd_ptr[LG-1:0]);
	assign wr_beat = i_valid && !i_abort && !dropping && !full;

	// Only committed beats are readable
	assign have_pkt = (rd_ptr != wr_cmt);
	assign load = have_pkt && (!o_rx_valid || i_rx_ready);

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr     <= '0;
			wr_cmt     <= '0;
			dropping   <= 1'b0;
			o_pkt_done <= 1'b0;
			o_pkt_drop <= 1'b0;
		end else begin
			o_pkt_done <= 1'b0;
			o_pkt_drop <= 1'b0;
			if (i_abort) begin
				// Rewind, count unless overflow already did
				wr_ptr     <= wr_cmt;
				dropping   <= 1'b0;
				o_pkt_drop <= !dropping;
			end else if (i_valid) begin
				if (dropping) begin
					dropping <= !i_beat.last;
				end else if (full) begin
					// Overflow
					wr_ptr     <= wr_cmt;
					o_pkt_drop <= 1'b1;
					dropping   <= !i_beat.last;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
					if (i_beat.last) begin
						// Commit whole packet
						wr_cmt     <= wr_ptr + 1'b1;
						o_pkt_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_beat) begin
			mem[wr_ptr[LG-1:0]] <= i_beat;
		end
	end

	//////////////////////////////////////////////////
	// Read side, one output register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rd_ptr     <= '0;
			o_rx_valid <= 1'b0;
		end else if (load) begin
			rd_ptr     <= rd_ptr + 1'b1;
			o_rx_valid <= 1'b1;
		end else if (i_rx_ready) begin
			o_rx_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			o_rx_beat <= mem[rd_ptr[LG-1:0]];
		end
	end

endmodule

// ==== logic/rx_csr.sv ====
// Wishbone classic register block for the receive port
// Ack comes one cycle after cyc and stb, for one cycle only
// Writes land on the ack edge; the control write needs sel[0]
// A write with all four sel bits to a counter clears it
// Counters wrap at 2**32
`timescale 1ns/1ns
`include "net_config.svh"

module rx_csr (
	input  logic                i_clk,
	input  logic                i_reset,
	input  csr_pkg::wb_req_t    i_wb,
	output csr_pkg::wb_rsp_t    o_wb,
	input  logic                i_pkt_done,
	input  logic                i_pkt_drop,
	output csr_pkg::csr_ctrl_t  o_ctrl
);

	localparam net_pkg::mac_t CPU_MAC = `NET_CPU_MAC;

	logic        ack_q;
	logic [31:0] rdata_q;
	logic [31:0] rd_word;
	logic [31:0] rx_drops;
	logic [31:0] rx_pkts;
	logic        access;
	logic        wr_en;
	logic        wr_full;

	// New transfer, first cycle only
	assign access  = i_wb.cyc && i_wb.stb && !ack_q;
	assign wr_en   = access && i_wb.we;
	assign wr_full = wr_en && (&i_wb.sel);

	assign o_wb = '{ack: ack_q, data: rdata_q};

	//////////////////////////////////////////////////
	// Bus handshake and read data
	//////////////////////////////////////////////////
	always_comb begin
		case (i_wb.addr)
			csr_pkg::CONTROL:  rd_word = {30'd0, o_ctrl};
			csr_pkg::MAC_HI:   rd_word = {16'd0, CPU_MAC[47:32]};
			csr_pkg::MAC_LO:   rd_word = CPU_MAC[31:0];
			csr_pkg::RX_DROPS: rd_word = rx_drops;
			csr_pkg::RX_PKTS:  rd_word = rx_pkts;
			default:           rd_word = 32'd0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Captured with ack
	always_ff @(posedge i_clk) begin
		if (access) begin
			rdata_q <= rd_word;
		end
	end

	// Control bits
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_ctrl <= '0;
		end else if (wr_en && i_wb.sel[0] && (i_wb.addr == csr_pkg::CONTROL)) begin
			o_ctrl <= csr_pkg::csr_ctrl_t'(i_wb.data[1:0]);
		end
	end

	//////////////////////////////////////////////////
	// Packet counters, clear wins over count
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rx_drops <= '0;
			rx_pkts  <= '0;
		end else begin
			if (wr_full && (i_wb.addr == csr_pkg::RX_DROPS)) begin
				rx_drops <= '0;
			end else if (i_pkt_drop) begin
				rx_drops <= rx_drops + 1'b1;
			end
			if (wr_full && (i_wb.addr == csr_pkg::RX_PKTS)) begin
				rx_pkts <= '0;
			end else if (i_pkt_done) begin
				rx_pkts <= rx_pkts + 1'b1;
			end
		end
	end

endmodule

// ==== logic/cpu_rx_top.sv ====
// CPU network port, receive side only
// Input stream is always accepted; there is no input ready
// Packets reach the output only once complete and accepted
`timescale 1ns/1ns

module cpu_rx_top (
	input  logic               i_clk,
	input  logic               i_reset,
	input  csr_pkg::wb_req_t   i_wb,
	output csr_pkg::wb_rsp_t   o_wb,
	input  logic               i_rx_valid,
	input  net_pkg::rx_beat_t  i_rx_beat,
	input  logic               i_rx_abort,
	output logic               o_rx_valid,
	output net_pkg::rx_beat_t  o_rx_beat,
	input  logic               i_rx_ready
);

	// Filter to FIFO
	logic               flt_valid;
	net_pkg::rx_beat_t  flt_beat;
	logic               flt_abort;
	// Status and control
	logic               pkt_done;
	logic               pkt_drop;
	csr_pkg::csr_ctrl_t ctrl;

	rx_mac_filter filter_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_ctrl  (ctrl),
		.i_valid (i_rx_valid),
		.i_beat  (i_rx_beat),
		.i_abort (i_rx_abort),
		.o_valid (flt_valid),
		.o_beat  (flt_beat),
		.o_abort (flt_abort)
	);

	rx_packet_fifo fifo_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_valid    (flt_valid),
		.i_beat     (flt_beat),
		.i_abort    (flt_abort),
		.o_rx_valid (o_rx_valid),
		.o_rx_beat  (o_rx_beat),
		.i_rx_ready (i_rx_ready),
		.o_pkt_done (pkt_done),
		.o_pkt_drop (pkt_drop)
	);

	rx_csr csr_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb       (i_wb),
		.o_wb       (o_wb),
		.i_pkt_done (pkt_done),
		.i_pkt_drop (pkt_drop),
		.o_ctrl     (ctrl)
	);

endmodule

// ==== tests/cpu_rx_tb.sv ====
// Testbench for the CPU receive port
// Packets and output ready come from $random with a fixed seed
// Expected packets and counter values come from a reference function
// that assumes an empty FIFO whenever a packet over 8 beats is sent
// Run ends at the first mismatch or after a fixed cycle limit
`timescale 1ns/1ns
`include "net_config.svh"

module cpu_rx_tb;

	localparam int SEED = 35997;
	// About ten times the stimulus length
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int FIFO_DEPTH = 1 << `NET_FIFO_LG;
	localparam net_pkg::mac_t CPU_MAC = `NET_CPU_MAC;
	localparam net_pkg::mac_t BCAST = 48'hffffffffffff;
	// Packet outcomes
	localparam int FATE_IGNORE = 0;
	localparam int FATE_DROP = 1;
	localparam int FATE_PASS = 2;

	logic clk;
	logic rst;
	csr_pkg::wb_req_t wb_req;
	csr_pkg::wb_rsp_t wb_rsp;
	logic rx_valid;
	net_pkg::rx_beat_t rx_beat;
	logic rx_abort;
	logic out_valid;
	net_pkg::rx_beat_t out_beat;
	logic rx_ready;

	integer seed = SEED;
	integer rdy_seed = SEED;
	logic rand_ready;
	int cycles;
	int in_flight;
	logic [31:0] exp_pkts;
	logic [31:0] exp_drops;
	logic [31:0] rd;
	csr_pkg::csr_ctrl_t ctrl_now;
	net_pkg::rx_beat_t exp_q [$];
	net_pkg::rx_beat_t exp_beat;
	// Packet being sent
	net_pkg::rx_beat_t pkt [64];

	cpu_rx_top dut_i (
		.i_clk      (clk),
		.i_reset    (rst),
		.i_wb       (wb_req),
		.o_wb       (wb_rsp),
		.i_rx_valid (rx_valid),
		.i_rx_beat  (rx_beat),
		.i_rx_abort (rx_abort),
		.o_rx_valid (out_valid),
		.o_rx_beat  (out_beat),
		.i_rx_ready (rx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Fate of one packet under the given control bits
	function automatic int expected_fate(input net_pkg::mac_t dest, input int len,
			input bit aborted, input csr_pkg::csr_ctrl_t ctrl);
		logic accepted;
		accepted = ctrl.promiscuous || (dest == CPU_MAC) || (dest == BCAST);
		if (!ctrl.enable) begin
			return FATE_IGNORE;
		end
		// Too short, aborted, or cannot fit an empty FIFO
		if (len < 2 || aborted || len > FIFO_DEPTH || !accepted) begin
			return FATE_DROP;
		end
		return FATE_PASS;
	endfunction

	function automatic int pick_range(input int lo, input int hi);
		integer r;
		r = $random(seed) & 32'h7fffffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	// Never own address nor broadcast
	function automatic net_pkg::mac_t random_other_mac();
		logic [31:0] r;
		r = $random(seed);
		return {16'h0a0b, r};
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	task automatic check_beat(input string sig, input net_pkg::rx_beat_t got,
			input net_pkg::rx_beat_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, sig, got, want);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string sig, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, sig, got, want);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// Outputs sampled at the falling edge before the handshake edge
	always @(negedge clk) begin
		if (!rst && out_valid && rx_ready) begin
			if (exp_q.size() == 0) begin
				$display("Output beat at %0t ns while no packet was expected", $time);
				$display("Something failed");
				$fatal(1);
			end else begin
				exp_beat = exp_q.pop_front();
				check_beat("o_rx_beat", out_beat, exp_beat);
				if (exp_beat.last) begin
					in_flight--;
				end
			end
		end
	end

	// Output ready is high three times in four when random
	always @(posedge clk) begin
		if (rand_ready) begin
			rx_ready <= ($random(rdy_seed) & 3) != 0;
		end else begin
			rx_ready <= 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// Bus and stream tasks
	//////////////////////////////////////////////////
	task automatic apply_reset();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic set_ready_mode(input logic random_on);
		@(posedge clk);
		rand_ready <= random_on;
	endtask

	task automatic bus_write(input csr_pkg::csr_addr_e reg_addr, input logic [31:0] wdata,
			input logic [3:0] wsel);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, addr: reg_addr, data: wdata, sel: wsel};
		@(negedge clk);
		while (!wb_rsp.ack) begin
			@(negedge clk);
		end
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic bus_read(input csr_pkg::csr_addr_e reg_addr, output logic [31:0] rdata);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: reg_addr, data: 32'd0, sel: 4'hf};
		@(negedge clk);
		while (!wb_rsp.ack) begin
			@(negedge clk);
		end
		// Read data valid with ack
		rdata = wb_rsp.data;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic set_control(input csr_pkg::csr_ctrl_t ctrl);
		logic [31:0] v;
		bus_write(csr_pkg::CONTROL, {30'd0, ctrl}, 4'h1);
		ctrl_now = ctrl;
		bus_read(csr_pkg::CONTROL, v);
		check_word("CONTROL", v, {30'd0, ctrl_now});
	endtask

	// Destination bytes 0..5 go out first with byte 0 in data bits 7:0
	task automatic build_packet(input net_pkg::mac_t dest, input int len);
		logic [31:0] r;
		logic [31:0] b;
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			b = $random(seed);
			pkt[i].data = r;
			pkt[i].last = (i == len - 1);
			pkt[i].bytes = pkt[i].last ? b[`NET_BYTES_W-1:0] : '0;
		end
		pkt[0].data = {dest[23:16], dest[31:24], dest[39:32], dest[47:40]};
		if (len > 1) begin
			pkt[1].data[15:0] = {dest[7:0], dest[15:8]};
		end
	endtask

	// Abort rides on beat abort_at or nowhere when -1
	task automatic send_packet(input net_pkg::mac_t dest, input int len, input int abort_at,
			input int max_out);
		int fate;
		build_packet(dest, len);
		fate = expected_fate(dest, len, abort_at >= 0, ctrl_now);
		while (in_flight >= max_out) begin
			@(posedge clk);
		end
		if (fate == FATE_PASS) begin
			for (int i = 0; i < len; i++) begin
				exp_q.push_back(pkt[i]);
			end
			in_flight++;
			exp_pkts++;
		end else if (fate == FATE_DROP) begin
			exp_drops++;
		end
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			rx_valid <= 1'b1;
			rx_beat <= pkt[i];
			rx_abort <= (i == abort_at);
		end
		@(posedge clk);
		rx_valid <= 1'b0;
		rx_abort <= 1'b0;
	endtask

	// Wait for the output to empty and for a drop pulse to reach the counter
	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic check_counters();
		logic [31:0] v;
		drain();
		bus_read(csr_pkg::RX_PKTS, v);
		check_word("RX_PKTS", v, exp_pkts);
		bus_read(csr_pkg::RX_DROPS, v);
		check_word("RX_DROPS", v, exp_drops);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		rst = 1'b1;
		wb_req = '0;
		rx_valid = 1'b0;
		rx_beat = '0;
		rx_abort = 1'b0;
		rx_ready = 1'b1;
		rand_ready = 1'b0;
		cycles = 0;
		in_flight = 0;
		exp_pkts = '0;
		exp_drops = '0;
		ctrl_now = '0;
		apply_reset();

		// Station address readback and reset values
		bus_read(csr_pkg::MAC_HI, rd);
		check_word("MAC_HI", rd, {16'd0, CPU_MAC[47:32]});
		bus_read(csr_pkg::MAC_LO, rd);
		check_word("MAC_LO", rd, CPU_MAC[31:0]);
		check_counters();

		// Own and broadcast pass in order
		set_control(2'b10);
		for (int n = 0; n < 6; n++) begin
			send_packet(n[0] ? BCAST : CPU_MAC, pick_range(2, 32), -1, 1);
		end
		check_counters();

		// Each rejected packet costs exactly one drop
		for (int n = 0; n < 3; n++) begin
			send_packet(random_other_mac(), pick_range(2, 32), -1, 1);
			check_counters();
			send_packet(CPU_MAC, 1, -1, 1);
			check_counters();
			send_packet(CPU_MAC, 8, pick_range(0, 7), 1);
			check_counters();
		end

		// Promiscuous
		set_control(2'b11);
		for (int n = 0; n < 4; n++) begin
			send_packet(random_other_mac(), pick_range(2, 32), -1, 1);
		end
		check_counters();

		// Overflow into an empty FIFO followed by a short packet
		set_control(2'b10);
		drain();
		send_packet(CPU_MAC, 40, -1, 1);
		send_packet(CPU_MAC, 6, -1, 1);
		check_counters();

		// Random ready with up to three short packets outstanding
		set_ready_mode(1'b1);
		for (int n = 0; n < 30; n++) begin
			case (pick_range(0, 2))
				0: send_packet(CPU_MAC, pick_range(1, 8), -1, 3);
				1: send_packet(BCAST, pick_range(1, 8), -1, 3);
				default: send_packet(random_other_mac(), pick_range(2, 8), -1, 3);
			endcase
			if (pick_range(0, 7) == 0) begin
				send_packet(CPU_MAC, 8, pick_range(0, 7), 3);
			end
		end
		check_counters();
		set_ready_mode(1'b0);

		// Counter clear followed by a disabled port
		bus_write(csr_pkg::RX_PKTS, 32'hffffffff, 4'hf);
		exp_pkts = '0;
		check_counters();
		set_control(2'b00);
		for (int n = 0; n < 3; n++) begin
			send_packet(CPU_MAC, pick_range(2, 32), -1, 1);
		end
		send_packet(random_other_mac(), 5, -1, 1);
		check_counters();

		drain();
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/net_pkg.sv
logic/csr_pkg.sv
logic/rx_mac_filter.sv
logic/rx_packet_fifo.sv
logic/rx_csr.sv
logic/cpu_rx_top.sv
tests/cpu_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the receive-port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f files.f \
	--top-module cpu_rx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcpu_rx_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
